// File: design/rv_consts.svh
// rv64 core constants for widths, memory size, queue depth and reset pc
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN        64      // register width
`define ILEN        32      // instruction and memory word width
`define MEM_ADDR_W  12      // word address, 4096 words
`define QUEUE_DEPTH 4       // fetch queue entries and initial credits
`define RESET_PC    64'h0   // first fetch byte address
`define REG_ADDR_W  5       // register index width

`endif

// File: design/rv_pkg.sv
// rv64 core types shared by fetch, queue and execute
`include "rv_consts.svh"

package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`ILEN-1:0] instr;
    } fetch_pkt_t;

endpackage

// File: design/mem_bus_if.sv
// memory bus between the masters, the arbiter and the unified memory
`timescale 1ns/100ps
`include "rv_consts.svh"

interface mem_bus_if;
    logic                   req;    // held until gnt
    logic                   we;
    logic [`MEM_ADDR_W-1:0] addr;   // word address
    logic [`ILEN-1:0]       wdata;
    logic                   gnt;
    logic                   rvalid; // one cycle after a granted read
    logic [`ILEN-1:0]       rdata;

    modport master (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );
endinterface

// File: design/if_stage.sv
// instruction fetch, one read in flight, credit flow control toward the queue
`timescale 1ns/100ps
`include "rv_consts.svh"

module if_stage import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              run_i,
    input  logic              halt_i,
    input  logic              redirect_i,
    input  logic [`XLEN-1:0]  redirect_pc_i,
    input  logic              credit_ret_i,
    mem_bus_if.master         bus,
    output logic              enq_valid_o,
    output fetch_pkt_t        enq_pkt_o
);

    localparam int CW = $clog2(`QUEUE_DEPTH + 1);

    logic [`XLEN-1:0] pc_q;
    logic [CW-1:0]    credits_q;
    logic             pend_q;   // read outstanding
    logic             enq_q;
    fetch_pkt_t       pkt_q;
    logic             take;

    assign bus.req   = run_i && !halt_i && !redirect_i && !pend_q && (credits_q != '0);
    assign bus.we    = 1'b0;
    assign bus.addr  = pc_q[`MEM_ADDR_W+1:2];
    assign bus.wdata = '0;

    // response accepted unless a redirect makes it stale
    assign take = bus.rvalid && pend_q && !redirect_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q      <= `RESET_PC;
            credits_q <= CW'(`QUEUE_DEPTH);
            pend_q    <= 1'b0;
            enq_q     <= 1'b0;
        end else if (redirect_i) begin
            pc_q      <= redirect_pc_i;
            credits_q <= CW'(`QUEUE_DEPTH);   // queue flushes this cycle
            pend_q    <= 1'b0;
            enq_q     <= 1'b0;
        end else begin
            if (bus.req && bus.gnt) begin
                pend_q <= 1'b1;
            end else if (bus.rvalid) begin
                pend_q <= 1'b0;
            end
            enq_q     <= take;
            credits_q <= credits_q - CW'(take) + CW'(credit_ret_i);
            if (take) begin
                pc_q <= pc_q + 64'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pkt_q <= '{pc: pc_q, instr: bus.rdata};
        end
    end

    assign enq_valid_o = enq_q;
    assign enq_pkt_o   = pkt_q;

endmodule

// File: design/fetch_queue.sv
// circular instruction queue, one credit back per pop, emptied on redirect
`timescale 1ns/100ps
`include "rv_consts.svh"

module fetch_queue import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       enq_valid_i,
    input  fetch_pkt_t enq_pkt_i,
    input  logic       deq_pop_i,
    output logic       deq_valid_o,
    output fetch_pkt_t deq_pkt_o,
    output logic       credit_ret_o
);

    localparam int AW = $clog2(`QUEUE_DEPTH);

    fetch_pkt_t     entry_q [`QUEUE_DEPTH];
    logic [AW-1:0]  wr_ptr_q;
    logic [AW-1:0]  rd_ptr_q;
    logic [AW:0]    count_q;
    logic           push;
    logic           pop;

    assign push = enq_valid_i && !flush_i;  // credits keep it from overflowing
    assign pop  = deq_pop_i && deq_valid_o && !flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + AW'(push);
            rd_ptr_q <= rd_ptr_q + AW'(pop);
            count_q  <= count_q + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[wr_ptr_q] <= enq_pkt_i;
        end
    end

    assign deq_valid_o  = (count_q != '0);
    assign deq_pkt_o    = entry_q[rd_ptr_q];
    assign credit_ret_o = pop;

endmodule

// File: design/regfile.sv
// integer register file, two async read ports, one write port, x0 reads zero
`timescale 1ns/100ps
`include "rv_consts.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    input  logic                   wb_en_i,
    input  logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  logic [`XLEN-1:0]       wb_data_i
);

    localparam int NREG = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs_q [NREG];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_en_i && wb_addr_i != '0) begin  // x0 never written
            regs_q[wb_addr_i] <= wb_data_i;
        end
    end

    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

// File: design/exec_stage.sv
// serial decode, execute, memory access, branch resolution and commit
`timescale 1ns/100ps
`include "rv_consts.svh"

module exec_stage import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   deq_valid_i,
    input  fetch_pkt_t             deq_pkt_i,
    output logic                   deq_pop_o,
    mem_bus_if.master              bus,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    output logic                   wb_en_o,
    output logic [`REG_ADDR_W-1:0] wb_addr_o,
    output logic [`XLEN-1:0]       wb_data_o,
    output logic                   redirect_o,
    output logic [`XLEN-1:0]       redirect_pc_o,
    output logic                   commit_valid_o,
    output logic [`XLEN-1:0]       commit_pc_o,
    output logic [`REG_ADDR_W-1:0] commit_rd_o,
    output logic [`XLEN-1:0]       commit_data_o,
    output logic                   halted_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_MEM, ST_LDRET, ST_HALT} state_e;

    state_e                 state_q;
    logic [`ILEN-1:0]       instr;
    logic [`XLEN-1:0]       pc;
    opcode_e                opc;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_s;
    logic [`XLEN-1:0]       imm_b;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       imm_j;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       alu_res;
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       eff_addr;
    logic [`XLEN-1:0]       ld_data;
    logic                   take_br;
    logic                   writes_rd;
    logic                   is_mem;
    logic                   pop;
    logic                   mem_we_q;
    logic [`MEM_ADDR_W-1:0] mem_addr_q;
    logic [`ILEN-1:0]       mem_wdata_q;
    logic [`REG_ADDR_W-1:0] ld_rd_q;
    logic                   commit_valid_q;
    logic                   redirect_q;
    logic                   halted_q;
    logic [`XLEN-1:0]       commit_pc_q;
    logic [`REG_ADDR_W-1:0] commit_rd_q;
    logic [`XLEN-1:0]       commit_data_q;
    logic [`XLEN-1:0]       redirect_pc_q;

    assign instr      = deq_pkt_i.instr;
    assign pc         = deq_pkt_i.pc;
    assign opc        = opcode_e'(instr[6:0]);
    assign rd         = instr[11:7];
    assign funct3     = instr[14:12];
    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        alu_op = ALU_ADD;
        if (opc == OPC_LUI) begin
            alu_op = ALU_LUI;
        end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (opc == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b100:  alu_op = ALU_XOR;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign op_b = (opc == OPC_OP) ? rs2_data_i : imm_i;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = rs1_data_i - op_b;
            ALU_AND: alu_res = rs1_data_i & op_b;
            ALU_OR:  alu_res = rs1_data_i | op_b;
            ALU_XOR: alu_res = rs1_data_i ^ op_b;
            ALU_LUI: alu_res = imm_u;
            default: alu_res = rs1_data_i + op_b;
        endcase
    end

    assign take_br   = (opc == OPC_BRANCH) && ((rs1_data_i == rs2_data_i) ^ funct3[0]);
    assign writes_rd = opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_JAL};
    assign is_mem    = (opc == OPC_LOAD) || (opc == OPC_STORE);
    assign result    = (opc == OPC_JAL) ? pc + 64'd4 : alu_res;   // link address
    assign eff_addr  = rs1_data_i + ((opc == OPC_STORE) ? imm_s : imm_i);
    assign ld_data   = {{(`XLEN-`ILEN){bus.rdata[`ILEN-1]}}, bus.rdata};

    // no pop while a redirect flushes the queue
    assign pop       = (state_q == ST_IDLE) && deq_valid_i && !redirect_q;
    assign deq_pop_o = pop;

    // write back one edge before commit so the next pop reads fresh data
    always_comb begin
        wb_en_o   = pop && writes_rd;
        wb_addr_o = rd;
        wb_data_o = result;
        if (state_q == ST_LDRET && bus.rvalid) begin
            wb_en_o   = 1'b1;
            wb_addr_o = ld_rd_q;
            wb_data_o = ld_data;
        end
    end

    assign bus.req   = (state_q == ST_MEM);
    assign bus.we    = mem_we_q;
    assign bus.addr  = mem_addr_q;
    assign bus.wdata = mem_wdata_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= ST_IDLE;
            commit_valid_q <= 1'b0;
            redirect_q     <= 1'b0;
            halted_q       <= 1'b0;
        end else begin
            commit_valid_q <= 1'b0;
            redirect_q     <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (pop) begin
                        commit_valid_q <= !is_mem;
                        redirect_q     <= take_br || (opc == OPC_JAL);
                        if (is_mem) begin
                            state_q <= ST_MEM;
                        end else if (opc == OPC_SYSTEM) begin
                            state_q <= ST_HALT;   // ebreak
                        end
                    end
                end
                ST_MEM: begin
                    if (bus.gnt) begin
                        commit_valid_q <= mem_we_q;   // stores retire on grant
                        state_q        <= mem_we_q ? ST_IDLE : ST_LDRET;
                    end
                end
                ST_LDRET: begin
                    if (bus.rvalid) begin
                        commit_valid_q <= 1'b1;
                        state_q        <= ST_IDLE;
                    end
                end
                default: halted_q <= 1'b1;   // raised after the ebreak commit
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            commit_pc_q   <= pc;
            commit_rd_q   <= writes_rd ? rd : '0;
            commit_data_q <= (writes_rd && rd != '0) ? result : '0;
            redirect_pc_q <= (opc == OPC_JAL) ? pc + imm_j : pc + imm_b;
            ld_rd_q       <= rd;
            mem_we_q      <= (opc == OPC_STORE);
            mem_addr_q    <= eff_addr[`MEM_ADDR_W+1:2];
            mem_wdata_q   <= rs2_data_i[`ILEN-1:0];
        end
        if (state_q == ST_LDRET && bus.rvalid) begin
            commit_rd_q   <= ld_rd_q;
            commit_data_q <= (ld_rd_q != '0) ? ld_data : '0;
        end
    end

    assign redirect_o     = redirect_q;
    assign redirect_pc_o  = redirect_pc_q;
    assign commit_valid_o = commit_valid_q;
    assign commit_pc_o    = commit_pc_q;
    assign commit_rd_o    = commit_rd_q;
    assign commit_data_o  = commit_data_q;
    assign halted_o       = halted_q;

endmodule

// File: design/mem_arbiter.sv
// fixed priority arbiter, data over fetch, read responses steered to their owner
`timescale 1ns/100ps

module mem_arbiter (
    input  logic      clk,
    input  logic      rst_n_i,
    mem_bus_if.slave  fetch_bus,
    mem_bus_if.slave  data_bus,
    mem_bus_if.master mem_bus
);

    logic owner_q;   // 1 when the read in flight belongs to data_bus
    logic sel_data;

    assign sel_data = data_bus.req;

    assign mem_bus.req   = data_bus.req || fetch_bus.req;
    assign mem_bus.we    = sel_data ? data_bus.we    : fetch_bus.we;
    assign mem_bus.addr  = sel_data ? data_bus.addr  : fetch_bus.addr;
    assign mem_bus.wdata = sel_data ? data_bus.wdata : fetch_bus.wdata;

    assign data_bus.gnt  = sel_data && mem_bus.gnt;
    assign fetch_bus.gnt = fetch_bus.req && !sel_data && mem_bus.gnt;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q <= 1'b0;
        end else if (mem_bus.req && mem_bus.gnt && !mem_bus.we) begin
            owner_q <= sel_data;
        end
    end

    assign data_bus.rvalid  = mem_bus.rvalid && owner_q;
    assign fetch_bus.rvalid = mem_bus.rvalid && !owner_q;
    assign data_bus.rdata   = mem_bus.rdata;
    assign fetch_bus.rdata  = mem_bus.rdata;

endmodule

// File: design/unified_mem.sv
// single port word memory, one cycle read latency, with a load port
`timescale 1ns/100ps
`include "rv_consts.svh"

module unified_mem (
    input  logic                   clk,
    mem_bus_if.slave               bus,
    input  logic                   load_we_i,
    input  logic [`MEM_ADDR_W-1:0] load_addr_i,
    input  logic [`ILEN-1:0]       load_data_i
);

    localparam int WORDS = 1 << `MEM_ADDR_W;

    logic [`ILEN-1:0] mem_q [WORDS];
    logic             rvalid_q;
    logic [`ILEN-1:0] rdata_q;

    assign bus.gnt = bus.req;   // never stalls

    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem_q[load_addr_i] <= load_data_i;
        end else if (bus.req && bus.we) begin
            mem_q[bus.addr] <= bus.wdata;
        end
        rvalid_q <= bus.req && !bus.we;
        rdata_q  <= mem_q[bus.addr];
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule

// File: design/rv_top.sv
// rv64 core top level with fetch, queue, execute, registers and shared memory
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_top import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   run_i,
    input  logic                   load_we_i,
    input  logic [`MEM_ADDR_W-1:0] load_addr_i,
    input  logic [`ILEN-1:0]       load_data_i,
    output logic                   commit_valid_o,
    output logic [`XLEN-1:0]       commit_pc_o,
    output logic [`REG_ADDR_W-1:0] commit_rd_o,
    output logic [`XLEN-1:0]       commit_data_o,
    output logic                   halted_o
);

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();
    mem_bus_if mem_bus ();

    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   credit_ret;
    logic                   enq_valid;
    fetch_pkt_t             enq_pkt;
    logic                   deq_valid;
    fetch_pkt_t             deq_pkt;
    logic                   deq_pop;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`XLEN-1:0]       wb_data;

    if_stage u_if_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .run_i         (run_i),
        .halt_i        (halted_o),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .credit_ret_i  (credit_ret),
        .bus           (fetch_bus),
        .enq_valid_o   (enq_valid),
        .enq_pkt_o     (enq_pkt)
    );

    fetch_queue u_fetch_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (redirect),
        .enq_valid_i  (enq_valid),
        .enq_pkt_i    (enq_pkt),
        .deq_pop_i    (deq_pop),
        .deq_valid_o  (deq_valid),
        .deq_pkt_o    (deq_pkt),
        .credit_ret_o (credit_ret)
    );

    exec_stage u_exec_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .deq_valid_i    (deq_valid),
        .deq_pkt_i      (deq_pkt),
        .deq_pop_o      (deq_pop),
        .bus            (data_bus),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .wb_en_o        (wb_en),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .halted_o       (halted_o)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_en_i    (wb_en),
        .wb_addr_i  (wb_addr),
        .wb_data_i  (wb_data)
    );

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .fetch_bus (fetch_bus),
        .data_bus  (data_bus),
        .mem_bus   (mem_bus)
    );

    unified_mem u_unified_mem (
        .clk         (clk),
        .bus         (mem_bus),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

endmodule

// File: tb/rv_top_sva.sv
// bound checks on fetch credits, bus read responses and commits after halt
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_top_sva (
    input logic                                 clk,
    input logic                                 rst_n_i,
    input logic [$clog2(`QUEUE_DEPTH + 1)-1:0]  credits_i,
    input logic [2:0]                           req_i,      // fetch, data, mem
    input logic [2:0]                           gnt_i,
    input logic [2:0]                           we_i,
    input logic [2:0]                           rvalid_i,
    input logic                                 commit_valid_i,
    input logic                                 halted_i
);

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
        credits_i <= `QUEUE_DEPTH)
        else $error("fetch credit count above the queue depth");

    for (genvar b = 0; b < 3; b++) begin : g_bus
        a_rvalid_after_read: assert property (@(posedge clk) disable iff (!rst_n_i)
            rvalid_i[b] |-> $past(req_i[b] && gnt_i[b] && !we_i[b]))
            else $error("rvalid on bus %0d without a granted read", b);
    end

    a_no_commit_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_i |-> !commit_valid_i)
        else $error("commit seen while the core is halted");

endmodule

bind rv_top rv_top_sva i_sva (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .credits_i      (u_if_stage.credits_q),
    .req_i          ({mem_bus.req, data_bus.req, fetch_bus.req}),
    .gnt_i          ({mem_bus.gnt, data_bus.gnt, fetch_bus.gnt}),
    .we_i           ({mem_bus.we, data_bus.we, fetch_bus.we}),
    .rvalid_i       ({mem_bus.rvalid, data_bus.rvalid, fetch_bus.rvalid}),
    .commit_valid_i (commit_valid_o),
    .halted_i       (halted_o)
);

// File: tb/rv_top_tb.sv
// rv64 core testbench with random programs checked against an isa model
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_top_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int PROG_LEN     = 40;
    localparam int DATA_BASE    = 1024;   // word index of the data region
    localparam int QUIET_CYCLES = 20;
    localparam int WATCHDOG_CYCLES =
        NUM_TESTS * (PROG_LEN * 20 + RESET_CYCLES + 2 * 256 + QUIET_CYCLES + 8);
    localparam logic [31:0] EBREAK = 32'h00100073;

    typedef struct packed {
        logic [63:0] pc;
        logic [4:0]  rd;
        logic [63:0] data;
    } commit_t;

    logic                   clk;
    logic                   rst_n_i;
    logic                   run_i;
    logic                   load_we_i;
    logic [`MEM_ADDR_W-1:0] load_addr_i;
    logic [`ILEN-1:0]       load_data_i;
    logic                   commit_valid_o;
    logic [`XLEN-1:0]       commit_pc_o;
    logic [`REG_ADDR_W-1:0] commit_rd_o;
    logic [`XLEN-1:0]       commit_data_o;
    logic                   halted_o;

    logic [31:0] lfsr_q;
    logic [31:0] img [4096];   // memory image shared by loader and model
    commit_t     exp_q [$];
    int          checks;
    int          errors;

    rv_top i_dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .run_i          (run_i),
        .load_we_i      (load_we_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .halted_o       (halted_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic lfsr_step();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h80200003;   // galois taps 32, 22, 2, 1
        end
        return b;
    endfunction

    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input int a, input int t);
        return (32'(a) ^ (32'(t) << 20)) * 32'h9e3779b1;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic gen_program(input int t);
        int          kind;
        int          tgt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [12:0] boff;
        logic [20:0] joff;
        for (int a = PROG_LEN; a < 256; a++) begin
            img[a] = EBREAK;   // fetch runs ahead of the halt
        end
        for (int a = DATA_BASE; a < DATA_BASE + 256; a++) begin
            img[a] = fill_word(a, t);
        end
        img[0] = {20'h1, 5'd8, 7'b0110111};   // lui x8 holds the data base
        img[PROG_LEN-1] = EBREAK;
        for (int i = 1; i < PROG_LEN - 1; i++) begin
            kind  = int'(rnd(4));
            rd    = 5'(rnd(3));
            rs1   = 5'(rnd(3));
            rs2   = 5'(rnd(3));
            imm   = 12'(rnd(12));
            upper = 20'(rnd(20));
            tgt   = i + 1 + int'(rnd(3));   // forward targets only
            if (tgt > PROG_LEN - 1) begin
                tgt = PROG_LEN - 1;
            end
            boff = 13'((tgt - i) * 4);
            joff = 21'((tgt - i) * 4);
            case (kind)
                0, 1:    img[i] = {imm, rs1, 3'b000, rd, 7'b0010011};
                2:       img[i] = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
                3:       img[i] = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
                4:       img[i] = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
                5:       img[i] = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
                6:       img[i] = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
                7:       img[i] = {upper, rd, 7'b0110111};
                8, 9:    img[i] = {7'b0, imm[2:0], 2'b00, 5'd8, 3'b010, rd, 7'b0000011};
                10, 11:  img[i] = {7'b0, rs2, 5'd8, 3'b010, imm[2:0], 2'b00, 7'b0100011};
                12, 13:  img[i] = {boff[12], boff[10:5], rs2, rs1, 2'b00, kind[0],
                                   boff[4:1], boff[11], 7'b1100011};
                14:      img[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd,
                                   7'b1101111};
                default: img[i] = {imm, rs1, 3'b000, 5'd0, 7'b0010011};   // addi x0
            endcase
        end
    endtask

    task automatic run_model();
        logic [63:0] regs [32];
        logic [63:0] pc;
        logic [63:0] next_pc;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] val;
        logic [63:0] addr;
        logic [31:0] ins;
        logic        wr;
        logic        done;
        commit_t     c;
        exp_q.delete();
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc = '0;
        done = 1'b0;
        while (!done && exp_q.size() < 2 * PROG_LEN) begin
            ins     = img[pc[13:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            next_pc = pc + 64'd4;
            wr      = 1'b1;
            val     = '0;
            case (ins[6:0])
                7'b0110011: begin
                    case (ins[14:12])
                        3'b000:  val = ins[30] ? a - b : a + b;
                        3'b100:  val = a ^ b;
                        3'b110:  val = a | b;
                        default: val = a & b;
                    endcase
                end
                7'b0010011: val = a + {{52{ins[31]}}, ins[31:20]};
                7'b0110111: val = {{32{ins[31]}}, ins[31:12], 12'h000};
                7'b0000011: begin
                    addr = a + {{52{ins[31]}}, ins[31:20]};
                    val  = {{32{img[addr[13:2]][31]}}, img[addr[13:2]]};
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    addr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
                    img[addr[13:2]] = b[31:0];
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    val     = pc + 64'd4;   // link address
                    next_pc = pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: begin
                    wr   = 1'b0;
                    done = 1'b1;   // ebreak
                end
            endcase
            c.pc   = pc;
            c.rd   = wr ? ins[11:7] : 5'd0;
            c.data = (wr && ins[11:7] != 5'd0) ? val : 64'd0;
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = val;
            end
            exp_q.push_back(c);
            pc = next_pc;
        end
    endtask

    task automatic load_word(input int a);
        @(negedge clk);
        load_we_i   = 1'b1;
        load_addr_i = a[`MEM_ADDR_W-1:0];
        load_data_i = img[a];
    endtask

    task automatic run_test(input int t);
        int idx;
        int errs_before;
        errs_before = errors;
        gen_program(t);
        @(negedge clk);
        run_i   = 1'b0;
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        compare_value("commit_valid_o", commit_valid_o, 64'd0);
        compare_value("halted_o", halted_o, 64'd0);
        for (int a = 0; a < 256; a++) begin
            load_word(a);
        end
        for (int a = DATA_BASE; a < DATA_BASE + 256; a++) begin
            load_word(a);
        end
        @(negedge clk);
        load_we_i = 1'b0;
        run_model();
        run_i = 1'b1;
        idx = 0;
        while (!halted_o) begin
            @(negedge clk);
            if (commit_valid_o) begin
                assert (idx < exp_q.size()) else begin
                    $display("commit seen after the end of the program");
                    errors++;
                end
                if (idx < exp_q.size()) begin
                    compare_value("commit_pc_o", commit_pc_o, exp_q[idx].pc);
                    compare_value("commit_rd_o", 64'(commit_rd_o), 64'(exp_q[idx].rd));
                    compare_value("commit_data_o", commit_data_o, exp_q[idx].data);
                end
                idx++;
            end
        end
        compare_value("commit_count", 64'(idx), 64'(exp_q.size()));
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            checks++;
            assert (!commit_valid_o && halted_o) else begin
                $display("core committed or left halt after ebreak");
                errors++;
            end
        end
        run_i = 1'b0;
        $display("test %0d done: %0d commits, %0d errors", t, idx, errors - errs_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        run_i       = 1'b0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        lfsr_q      = 32'ha2f96573;
        checks      = 0;
        errors      = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/rv_pkg.sv
design/mem_bus_if.sv
design/if_stage.sv
design/fetch_queue.sv
design/regfile.sv
design/exec_stage.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/rv_top.sv
tb/rv_top_sva.sv
tb/rv_top_tb.sv
